// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath width, one byte
`define CPU_DATA_W 8

// Address bus width
`define CPU_ADDR_W 16

// First opcode fetch after reset
`define CPU_RESET_PC 16'h0200

// High byte of every zero-page access
`define CPU_ZP_HI 8'h00

`endif

// ==== cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

    // Standard 6502 encodings of the supported instructions
    typedef enum logic [7:0] {
        OP_NOP     = 8'hEA,
        OP_SEC     = 8'h38, OP_CLC    = 8'h18, OP_CLV    = 8'hB8,
        OP_TAX     = 8'hAA, OP_TAY    = 8'hA8,
        OP_TXA     = 8'h8A, OP_TYA    = 8'h98,
        OP_INX     = 8'hE8, OP_INY    = 8'hC8,
        OP_DEX     = 8'hCA, OP_DEY    = 8'h88,
        OP_ASL_A   = 8'h0A, OP_LSR_A  = 8'h4A,
        OP_ROL_A   = 8'h2A, OP_ROR_A  = 8'h6A,
        OP_LDA_IMM = 8'hA9, OP_LDA_ZP = 8'hA5,
        OP_LDX_IMM = 8'hA2, OP_LDX_ZP = 8'hA6,
        OP_LDY_IMM = 8'hA0, OP_LDY_ZP = 8'hA4,
        OP_AND_IMM = 8'h29, OP_AND_ZP = 8'h25,
        OP_ORA_IMM = 8'h09, OP_ORA_ZP = 8'h05,
        OP_EOR_IMM = 8'h49, OP_EOR_ZP = 8'h45,
        OP_ADC_IMM = 8'h69, OP_ADC_ZP = 8'h65,
        OP_STA_ZP  = 8'h85, OP_STX_ZP = 8'h86, OP_STY_ZP = 8'h84,
        OP_BCS     = 8'hB0, OP_BCC    = 8'h90,
        OP_BEQ     = 8'hF0, OP_BNE    = 8'hD0,
        OP_BMI     = 8'h30, OP_BPL    = 8'h10,
        OP_JMP_ABS = 8'h4C
    } opcode_e;

    typedef enum logic [3:0] {
        PASS_A,
        PASS_B,
        AND,
        OR,
        XOR,
        ADC,
        INC,
        DEC,
        ASL,
        LSR,
        ROL,
        ROR,
        SET_C,
        CLR_C,
        CLR_V
    } alu_op_e;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flags_t;

    // One bit per flag, set where the flag is written
    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flag_mask_t;

endpackage

`default_nettype wire

// ==== cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

    typedef enum logic [2:0] {
        FETCH,
        EXEC,      // Register-only instructions
        OPERAND,   // Immediate, branch offset or JMP low byte
        ZP_ADDR,
        ZP_READ,
        ZP_WRITE,
        ABS_HI     // JMP high byte
    } state_e;

    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y
    } reg_sel_e;

    typedef enum logic [2:0] {
        PC_HOLD,
        PC_INC,
        PC_INC_LATCH,  // Also captures the operand byte
        PC_BRANCH,
        PC_JUMP
    } pc_op_e;

    typedef enum logic {
        ADDR_PC,
        ADDR_ZP
    } addr_sel_e;

endpackage

`default_nettype wire

// ==== cpu_alu.sv ====
`include "cpu_cfg.svh"

`default_nettype none

module cpu_alu (
    input  cpu_isa_pkg::alu_op_e   alu_op,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  cpu_isa_pkg::flags_t    flags_in,
    output logic [`CPU_DATA_W-1:0] result,
    output cpu_isa_pkg::flags_t    flags_next
);
    import cpu_isa_pkg::*;

    localparam int W = `CPU_DATA_W;

    logic [W:0] sum;
    logic       carry;
    logic       ovf;

    assign sum = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, flags_in.c};

    always_comb begin
        result = a;
        carry  = flags_in.c;
        ovf    = flags_in.v;
        case (alu_op)
            PASS_B: result = b;
            AND:    result = a & b;
            OR:     result = a | b;
            XOR:    result = a ^ b;
            ADC: begin
                result = sum[W-1:0];
                carry  = sum[W];
                // Same-sign operands giving a different-sign sum
                ovf    = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
            end
            INC:    result = a + 1'b1;
            DEC:    result = a - 1'b1;
            ASL:    {carry, result} = {a, 1'b0};
            LSR:    {result, carry} = {1'b0, a};
            ROL:    {carry, result} = {a, flags_in.c};
            ROR:    {result, carry} = {flags_in.c, a};
            SET_C:  carry = 1'b1;
            CLR_C:  carry = 1'b0;
            CLR_V:  ovf = 1'b0;
            default: begin
                result = a;
            end
        endcase

        flags_next.n = result[W-1];
        flags_next.v = ovf;
        flags_next.z = (result == '0);
        flags_next.c = carry;
    end

endmodule

`default_nettype wire

// ==== cpu_regs.sv ====
`include "cpu_cfg.svh"

`default_nettype none

module cpu_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_ctrl_pkg::reg_sel_e  src_sel,
    input  cpu_ctrl_pkg::reg_sel_e  dst_sel,
    input  logic                    reg_we,
    input  cpu_isa_pkg::flag_mask_t flag_mask,
    input  logic [`CPU_DATA_W-1:0]  result,
    input  cpu_isa_pkg::flags_t     flags_next,
    output logic [`CPU_DATA_W-1:0]  src_value,
    output cpu_isa_pkg::flags_t     flags
);
    import cpu_ctrl_pkg::*;

    logic [`CPU_DATA_W-1:0] reg_a;
    logic [`CPU_DATA_W-1:0] reg_x;
    logic [`CPU_DATA_W-1:0] reg_y;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_a <= '0;
            reg_x <= '0;
            reg_y <= '0;
            flags <= '0;
        end else begin
            if (reg_we) begin
                case (dst_sel)
                    REG_X:   reg_x <= result;
                    REG_Y:   reg_y <= result;
                    default: reg_a <= result;
                endcase
            end
            // Only flags named in the mask change
            if (flag_mask.n) begin
                flags.n <= flags_next.n;
            end
            if (flag_mask.v) begin
                flags.v <= flags_next.v;
            end
            if (flag_mask.z) begin
                flags.z <= flags_next.z;
            end
            if (flag_mask.c) begin
                flags.c <= flags_next.c;
            end
        end
    end

    always_comb begin
        case (src_sel)
            REG_X:   src_value = reg_x;
            REG_Y:   src_value = reg_y;
            default: src_value = reg_a;
        endcase
    end

endmodule

`default_nettype wire

// ==== cpu_address_unit.sv ====
`include "cpu_cfg.svh"

`default_nettype none

module cpu_address_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_ctrl_pkg::pc_op_e    pc_op,
    input  cpu_ctrl_pkg::addr_sel_e addr_sel,
    input  logic [`CPU_DATA_W-1:0]  mem_rdata,
    output logic [`CPU_ADDR_W-1:0]  mem_addr
);
    import cpu_ctrl_pkg::*;

    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] pc_inc;
    logic [`CPU_ADDR_W-1:0] rel_offset;
    logic [`CPU_DATA_W-1:0] oper_lo;

    assign pc_inc     = pc + 1'b1;
    assign rel_offset = {{(`CPU_ADDR_W-`CPU_DATA_W){mem_rdata[`CPU_DATA_W-1]}}, mem_rdata};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CPU_RESET_PC;
        end else begin
            case (pc_op)
                PC_INC, PC_INC_LATCH: pc <= pc_inc;
                PC_BRANCH:            pc <= pc_inc + rel_offset;  // Relative to next opcode
                PC_JUMP:              pc <= {mem_rdata, oper_lo};
                default:              pc <= pc;
            endcase
        end
    end

    // Zero-page address or JMP low byte
    always_ff @(posedge clk) begin
        if (pc_op == PC_INC_LATCH) begin
            oper_lo <= mem_rdata;
        end
    end

    assign mem_addr = (addr_sel == ADDR_ZP) ? {`CPU_ZP_HI, oper_lo} : pc;

endmodule

`default_nettype wire

// ==== cpu_sequencer.sv ====
`include "cpu_cfg.svh"

`default_nettype none

module cpu_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CPU_DATA_W-1:0]  mem_rdata,
    input  cpu_isa_pkg::flags_t     flags,
    output cpu_ctrl_pkg::pc_op_e    pc_op,
    output cpu_ctrl_pkg::addr_sel_e addr_sel,
    output cpu_isa_pkg::alu_op_e    alu_op,
    output cpu_ctrl_pkg::reg_sel_e  src_sel,
    output cpu_ctrl_pkg::reg_sel_e  dst_sel,
    output logic                    reg_we,
    output cpu_isa_pkg::flag_mask_t flag_mask,
    output logic                    mem_we
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam flag_mask_t MASK_NONE = '{default: 1'b0};
    localparam flag_mask_t MASK_C    = '{c: 1'b1, default: 1'b0};
    localparam flag_mask_t MASK_V    = '{v: 1'b1, default: 1'b0};
    localparam flag_mask_t MASK_NZ   = '{n: 1'b1, z: 1'b1, default: 1'b0};
    localparam flag_mask_t MASK_NZC  = '{n: 1'b1, z: 1'b1, c: 1'b1, v: 1'b0};
    localparam flag_mask_t MASK_NVZC = '{default: 1'b1};

    state_e     state;
    state_e     state_next;
    opcode_e    op_q;
    opcode_e    op_cur;

    state_e     dec_entry;
    alu_op_e    dec_alu;
    reg_sel_e   dec_src;
    reg_sel_e   dec_dst;
    logic       dec_we;
    flag_mask_t dec_mask;
    logic       dec_store;
    logic       dec_branch;
    logic       dec_jmp;
    logic       taken;

    // Opcode comes straight off the bus during FETCH
    assign op_cur = (state == FETCH) ? opcode_e'(mem_rdata) : op_q;

    always_comb begin
        if (op_cur inside {OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_AND_IMM, OP_ORA_IMM,
                           OP_EOR_IMM, OP_ADC_IMM, OP_BCS, OP_BCC, OP_BEQ, OP_BNE,
                           OP_BMI, OP_BPL, OP_JMP_ABS}) begin
            dec_entry = OPERAND;
        end else if (op_cur inside {OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP, OP_AND_ZP, OP_ORA_ZP,
                                    OP_EOR_ZP, OP_ADC_ZP, OP_STA_ZP, OP_STX_ZP,
                                    OP_STY_ZP}) begin
            dec_entry = ZP_ADDR;
        end else begin
            dec_entry = EXEC;  // Implied ops and unknown opcodes
        end

        case (op_cur)
            OP_SEC:                                dec_alu = SET_C;
            OP_CLC:                                dec_alu = CLR_C;
            OP_CLV:                                dec_alu = CLR_V;
            OP_INX, OP_INY:                        dec_alu = INC;
            OP_DEX, OP_DEY:                        dec_alu = DEC;
            OP_ASL_A:                              dec_alu = ASL;
            OP_LSR_A:                              dec_alu = LSR;
            OP_ROL_A:                              dec_alu = ROL;
            OP_ROR_A:                              dec_alu = ROR;
            OP_AND_IMM, OP_AND_ZP:                 dec_alu = AND;
            OP_ORA_IMM, OP_ORA_ZP:                 dec_alu = OR;
            OP_EOR_IMM, OP_EOR_ZP:                 dec_alu = XOR;
            OP_ADC_IMM, OP_ADC_ZP:                 dec_alu = ADC;
            OP_LDA_IMM, OP_LDA_ZP, OP_LDX_IMM,
            OP_LDX_ZP, OP_LDY_IMM, OP_LDY_ZP:      dec_alu = PASS_B;
            default:                               dec_alu = PASS_A;
        endcase

        case (op_cur)
            OP_TXA, OP_INX, OP_DEX, OP_STX_ZP:     dec_src = REG_X;
            OP_TYA, OP_INY, OP_DEY, OP_STY_ZP:     dec_src = REG_Y;
            default:                               dec_src = REG_A;
        endcase

        case (op_cur)
            OP_TAX, OP_INX, OP_DEX, OP_LDX_IMM, OP_LDX_ZP: dec_dst = REG_X;
            OP_TAY, OP_INY, OP_DEY, OP_LDY_IMM, OP_LDY_ZP: dec_dst = REG_Y;
            default:                                       dec_dst = REG_A;
        endcase

        dec_we = op_cur inside {OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_INX, OP_INY, OP_DEX,
                                OP_DEY, OP_ASL_A, OP_LSR_A, OP_ROL_A, OP_ROR_A,
                                OP_LDA_IMM, OP_LDA_ZP, OP_LDX_IMM, OP_LDX_ZP, OP_LDY_IMM,
                                OP_LDY_ZP, OP_AND_IMM, OP_AND_ZP, OP_ORA_IMM, OP_ORA_ZP,
                                OP_EOR_IMM, OP_EOR_ZP, OP_ADC_IMM, OP_ADC_ZP};

        case (op_cur)
            OP_SEC, OP_CLC:                         dec_mask = MASK_C;
            OP_CLV:                                 dec_mask = MASK_V;
            OP_ASL_A, OP_LSR_A, OP_ROL_A, OP_ROR_A: dec_mask = MASK_NZC;
            OP_ADC_IMM, OP_ADC_ZP:                  dec_mask = MASK_NVZC;
            default:                                dec_mask = dec_we ? MASK_NZ : MASK_NONE;
        endcase

        dec_store  = op_cur inside {OP_STA_ZP, OP_STX_ZP, OP_STY_ZP};
        dec_branch = op_cur inside {OP_BCS, OP_BCC, OP_BEQ, OP_BNE, OP_BMI, OP_BPL};
        dec_jmp    = (op_cur == OP_JMP_ABS);
    end

    always_comb begin
        case (op_q)
            OP_BCS:  taken = flags.c;
            OP_BCC:  taken = !flags.c;
            OP_BEQ:  taken = flags.z;
            OP_BNE:  taken = !flags.z;
            OP_BMI:  taken = flags.n;
            OP_BPL:  taken = !flags.n;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        pc_op      = PC_HOLD;
        addr_sel   = ADDR_PC;
        alu_op     = dec_alu;
        src_sel    = dec_src;
        dst_sel    = dec_dst;
        reg_we     = 1'b0;
        flag_mask  = MASK_NONE;
        mem_we     = 1'b0;
        state_next = FETCH;
        case (state)
            FETCH: begin
                pc_op      = PC_INC;
                state_next = dec_entry;
            end
            EXEC: begin
                reg_we    = dec_we;
                flag_mask = dec_mask;
            end
            OPERAND: begin
                if (dec_branch) begin
                    pc_op = taken ? PC_BRANCH : PC_INC;
                end else if (dec_jmp) begin
                    pc_op      = PC_INC_LATCH;  // Keep the low target byte
                    state_next = ABS_HI;
                end else begin
                    pc_op     = PC_INC;
                    reg_we    = dec_we;
                    flag_mask = dec_mask;
                end
            end
            ZP_ADDR: begin
                pc_op      = PC_INC_LATCH;
                state_next = dec_store ? ZP_WRITE : ZP_READ;
            end
            ZP_READ: begin
                addr_sel  = ADDR_ZP;
                reg_we    = dec_we;
                flag_mask = dec_mask;
            end
            ZP_WRITE: begin
                addr_sel = ADDR_ZP;
                mem_we   = 1'b1;  // Data is src_value of the stored register
            end
            ABS_HI: begin
                pc_op = PC_JUMP;
            end
            default: begin
                state_next = FETCH;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH;
            op_q  <= OP_NOP;
        end else begin
            state <= state_next;
            if (state == FETCH) begin
                op_q <= op_cur;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`include "cpu_cfg.svh"

`default_nettype none

module cpu_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    output logic [`CPU_ADDR_W-1:0] mem_addr,
    output logic [`CPU_DATA_W-1:0] mem_wdata,
    output logic                   mem_we
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    pc_op_e                 pc_op;
    addr_sel_e              addr_sel;
    alu_op_e                alu_op;
    reg_sel_e               src_sel;
    reg_sel_e               dst_sel;
    logic                   reg_we;
    flag_mask_t             flag_mask;
    flags_t                 flags;
    flags_t                 flags_next;
    logic [`CPU_DATA_W-1:0] src_value;
    logic [`CPU_DATA_W-1:0] result;

    cpu_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .flags     (flags),
        .pc_op     (pc_op),
        .addr_sel  (addr_sel),
        .alu_op    (alu_op),
        .src_sel   (src_sel),
        .dst_sel   (dst_sel),
        .reg_we    (reg_we),
        .flag_mask (flag_mask),
        .mem_we    (mem_we)
    );

    cpu_address_unit u_address_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_op     (pc_op),
        .addr_sel  (addr_sel),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr)
    );

    cpu_alu u_alu (
        .alu_op     (alu_op),
        .a          (src_value),
        .b          (mem_rdata),  // Operand byte or zero-page data
        .flags_in   (flags),
        .result     (result),
        .flags_next (flags_next)
    );

    cpu_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_sel    (src_sel),
        .dst_sel    (dst_sel),
        .reg_we     (reg_we),
        .flag_mask  (flag_mask),
        .result     (result),
        .flags_next (flags_next),
        .src_value  (src_value),
        .flags      (flags)
    );

    assign mem_wdata = src_value;

endmodule

`default_nettype wire

// ==== cpu_core_assertions.sv ====
`include "cpu_cfg.svh"

`default_nettype none

module cpu_core_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic [`CPU_ADDR_W-1:0] mem_addr,
    input logic                   mem_we
);

    // Stores only ever target zero page
    zp_write: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we |-> (mem_addr[`CPU_ADDR_W-1:`CPU_DATA_W] == `CPU_ZP_HI))
        else $error("mem_we high with mem_addr 0x%h outside zero page", mem_addr);

    single_write: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we |=> !mem_we)
        else $error("mem_we high in two consecutive cycles");

    addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(mem_addr))
        else $error("mem_addr has unknown bits");

endmodule

bind cpu_core cpu_core_assertions u_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_addr (mem_addr),
    .mem_we   (mem_we)
);

`default_nettype wire

// ==== tb_cpu_core.sv ====
`include "cpu_cfg.svh"

`default_nettype none

module tb_cpu_core;
    import cpu_isa_pkg::*;

    localparam logic [15:0] PROG_BASE = 16'h0200;
    localparam int          SLOTS     = 32;

    // Rows are the opcode pools of tests 1 to 4
    localparam logic [7:0] MIX [4][13] = '{
        '{OP_LDA_IMM, OP_LDA_ZP, OP_LDX_IMM, OP_LDX_ZP, OP_LDY_IMM, OP_LDY_ZP, OP_TAX,
          OP_TAY, OP_TXA, OP_TYA, OP_STA_ZP, OP_STX_ZP, OP_STY_ZP},
        '{OP_AND_IMM, OP_AND_ZP, OP_ORA_IMM, OP_ORA_ZP, OP_EOR_IMM, OP_EOR_ZP, OP_ADC_IMM,
          OP_ADC_ZP, OP_SEC, OP_CLC, OP_CLV, OP_LDA_IMM, OP_LDA_ZP},
        '{OP_INX, OP_INY, OP_DEX, OP_DEY, OP_ASL_A, OP_LSR_A, OP_ROL_A, OP_ROR_A,
          OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_SEC, OP_CLC},
        '{OP_LDA_IMM, OP_ADC_IMM, OP_SEC, OP_CLC, OP_EOR_IMM, OP_AND_IMM, OP_LDA_ZP,
          OP_ADC_ZP, OP_TXA, OP_INX, OP_DEX, OP_ASL_A, OP_LSR_A}
    };
    localparam logic [7:0] BRANCHES [6] = '{OP_BCS, OP_BCC, OP_BEQ, OP_BNE, OP_BMI, OP_BPL};

    logic        clk;
    logic        rst_n;
    logic [7:0]  mem_rdata;
    logic [15:0] mem_addr;
    logic [7:0]  mem_wdata;
    logic        mem_we;
    logic [7:0]  mem [0:65535];

    logic [31:0] rng_state;
    logic [15:0] gen_pc;
    logic [15:0] halt_addr;
    int          halt_cyc;
    int          n_instr;
    logic [7:0]  m_a, m_x, m_y;
    logic        m_n, m_v, m_z, m_c;
    logic [15:0] exp_addr[$];
    logic [7:0]  exp_data[$];
    int          exp_cyc[$];
    logic [15:0] obs_addr[$];
    logic [7:0]  obs_data[$];
    int          obs_cyc[$];
    int          cyc = 0;
    int          total_cycles = 0;
    int          cycle_limit;
    int          err_count;
    int          mon_errs = 0;

    cpu_core u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

    assign mem_rdata = mem[mem_addr];

    always #4 clk = ~clk;

    // Write log, reset checks and run limit
    always @(posedge clk) begin
        total_cycles <= total_cycles + 1;
        if (total_cycles >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end else if (!rst_n) begin
            cyc <= 0;
            obs_addr.delete();
            obs_data.delete();
            obs_cyc.delete();
            if (mem_we !== 1'b0) begin
                $display("[ERROR] mem_we = 0x%h during reset, expected 0x0", mem_we);
                mon_errs = mon_errs + 1;
            end
        end else begin
            if (mem_we) begin
                obs_addr.push_back(mem_addr);
                obs_data.push_back(mem_wdata);
                obs_cyc.push_back(cyc);
            end
            cyc <= cyc + 1;
        end
    end

    function automatic logic [31:0] xorshift_next();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    // 0 none, 1 immediate, 2 zero-page read, 3 zero-page store
    function automatic int operand_kind(input logic [7:0] op);
        case (op)
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM,
            OP_ADC_IMM:                                         return 1;
            OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP, OP_AND_ZP, OP_ORA_ZP, OP_EOR_ZP,
            OP_ADC_ZP:                                          return 2;
            OP_STA_ZP, OP_STX_ZP, OP_STY_ZP:                    return 3;
            default:                                            return 0;
        endcase
    endfunction

    function automatic logic [7:0] store_for(input logic [7:0] op);
        case (op)
            OP_INX, OP_DEX, OP_LDX_IMM, OP_LDX_ZP: return OP_STX_ZP;
            OP_INY, OP_DEY, OP_LDY_IMM, OP_LDY_ZP: return OP_STY_ZP;
            default:                               return OP_STA_ZP;
        endcase
    endfunction

    task automatic emit_byte(input logic [7:0] b);
        mem[gen_pc] = b;
        gen_pc = gen_pc + 16'd1;
    endtask

    task automatic emit_instr(input logic [7:0] op);
        logic [31:0] r;
        r = xorshift_next();
        emit_byte(op);
        n_instr = n_instr + 1;
        case (operand_kind(op))
            1:       emit_byte(r[7:0]);
            2:       emit_byte({1'b0, r[6:0]});  // Preloaded data area
            3:       emit_byte({1'b1, r[6:0]});  // Store area
            default: ;
        endcase
    endtask

    task automatic emit_jmp(input logic [15:0] target);
        emit_byte(OP_JMP_ABS);
        emit_byte(target[7:0]);
        emit_byte(target[15:8]);
        n_instr = n_instr + 1;
    endtask

    task automatic fill_memory();
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[i] = 8'(i ^ (i >> 8)) ^ 8'hC3;
        end
    endtask

    task automatic build_program(input int test_id);
        logic [31:0] r;
        logic [7:0]  op;
        int          i;
        int          idx;
        fill_memory();
        for (i = 0; i < 128; i++) begin
            r = xorshift_next();
            mem[i] = r[7:0];
        end
        gen_pc  = PROG_BASE;
        n_instr = 0;
        for (i = 0; i < SLOTS && test_id > 0; i++) begin
            r   = xorshift_next();
            idx = int'(r[15:0] % 16'd13);
            op  = MIX[test_id-1][idx];
            emit_instr(op);
            if (test_id == 4) begin
                emit_byte(BRANCHES[int'(r[23:16] % 8'd6)]);
                emit_byte(8'h02);  // Skips the store below
                n_instr = n_instr + 1;
                emit_instr(OP_STA_ZP);
                if (r[29:28] == 2'b00) begin
                    emit_jmp(gen_pc + 16'd5);
                    emit_instr(OP_STA_ZP);
                end
            end else if (test_id > 1) begin
                emit_instr(store_for(op));
            end
        end
        emit_jmp(gen_pc);
    endtask

    task automatic set_nz(input logic [7:0] v);
        m_n = v[7];
        m_z = (v == 8'h00);
    endtask

    task automatic expect_write(input logic [15:0] addr, input logic [7:0] data, input int c);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_cyc.push_back(c);
    endtask

    // Instruction-level model of the program in mem
    task automatic run_model();
        logic [15:0] pc;
        logic [15:0] target;
        logic [7:0]  op;
        logic [7:0]  opnd;
        logic [7:0]  val;
        logic [8:0]  sum;
        logic        taken;
        logic        branch;
        logic        done;
        int          mcyc;
        pc   = PROG_BASE;
        mcyc = 0;
        done = 1'b0;
        {m_a, m_x, m_y} = '0;
        {m_n, m_v, m_z, m_c} = '0;
        exp_addr.delete();
        exp_data.delete();
        exp_cyc.delete();
        while (!done) begin
            op   = mem[pc];
            opnd = mem[pc + 16'd1];
            val  = (operand_kind(op) == 2) ? mem[{8'h00, opnd}] : opnd;
            case (op)
                OP_SEC:                m_c = 1'b1;
                OP_CLC:                m_c = 1'b0;
                OP_CLV:                m_v = 1'b0;
                OP_TAX:                m_x = m_a;
                OP_TAY:                m_y = m_a;
                OP_TXA:                m_a = m_x;
                OP_TYA:                m_a = m_y;
                OP_INX:                m_x = m_x + 8'd1;
                OP_INY:                m_y = m_y + 8'd1;
                OP_DEX:                m_x = m_x - 8'd1;
                OP_DEY:                m_y = m_y - 8'd1;
                OP_ASL_A:              {m_c, m_a} = {m_a, 1'b0};
                OP_LSR_A:              {m_a, m_c} = {1'b0, m_a};
                OP_ROL_A:              {m_c, m_a} = {m_a, m_c};
                OP_ROR_A:              {m_a, m_c} = {m_c, m_a};
                OP_LDA_IMM, OP_LDA_ZP: m_a = val;
                OP_LDX_IMM, OP_LDX_ZP: m_x = val;
                OP_LDY_IMM, OP_LDY_ZP: m_y = val;
                OP_AND_IMM, OP_AND_ZP: m_a = m_a & val;
                OP_ORA_IMM, OP_ORA_ZP: m_a = m_a | val;
                OP_EOR_IMM, OP_EOR_ZP: m_a = m_a ^ val;
                OP_ADC_IMM, OP_ADC_ZP: begin
                    sum = {1'b0, m_a} + {1'b0, val} + {8'd0, m_c};
                    m_v = ~(m_a[7] ^ val[7]) & (m_a[7] ^ sum[7]);
                    m_c = sum[8];
                    m_a = sum[7:0];
                end
                OP_STA_ZP:             expect_write({8'h00, opnd}, m_a, mcyc + 2);
                OP_STX_ZP:             expect_write({8'h00, opnd}, m_x, mcyc + 2);
                OP_STY_ZP:             expect_write({8'h00, opnd}, m_y, mcyc + 2);
                default:               ;
            endcase
            case (op)
                OP_TXA, OP_TYA, OP_ASL_A, OP_LSR_A, OP_ROL_A, OP_ROR_A, OP_LDA_IMM,
                OP_LDA_ZP, OP_AND_IMM, OP_AND_ZP, OP_ORA_IMM, OP_ORA_ZP, OP_EOR_IMM,
                OP_EOR_ZP, OP_ADC_IMM, OP_ADC_ZP:               set_nz(m_a);
                OP_TAX, OP_INX, OP_DEX, OP_LDX_IMM, OP_LDX_ZP: set_nz(m_x);
                OP_TAY, OP_INY, OP_DEY, OP_LDY_IMM, OP_LDY_ZP: set_nz(m_y);
                default:                                        ;
            endcase
            branch = 1'b1;
            case (op)
                OP_BCS:  taken = m_c;
                OP_BCC:  taken = !m_c;
                OP_BEQ:  taken = m_z;
                OP_BNE:  taken = !m_z;
                OP_BMI:  taken = m_n;
                OP_BPL:  taken = !m_n;
                default: begin
                    branch = 1'b0;
                    taken  = 1'b0;
                end
            endcase
            if (op == OP_JMP_ABS) begin
                target = {mem[pc + 16'd2], opnd};
                if (target == pc) begin
                    halt_addr = pc;
                    halt_cyc  = mcyc;
                    done      = 1'b1;
                end
                pc   = target;
                mcyc = mcyc + 3;
            end else if (branch) begin
                pc   = pc + 16'd2 + (taken ? {{8{opnd[7]}}, opnd} : 16'd0);
                mcyc = mcyc + 2;
            end else begin
                pc   = pc + ((operand_kind(op) == 0) ? 16'd1 : 16'd2);
                mcyc = mcyc + ((operand_kind(op) >= 2) ? 3 : 2);
            end
        end
    endtask

    task automatic compare_writes();
        int i;
        for (i = 0; i < exp_addr.size(); i++) begin
            if (i >= obs_addr.size()) begin
                $display("Missing write %0d: data 0x%h to address 0x%h never appeared",
                         i, exp_data[i], exp_addr[i]);
                err_count = err_count + 1;
            end else begin
                if (obs_addr[i] != exp_addr[i]) begin
                    $display("[ERROR] mem_addr = 0x%h, expected 0x%h (write %0d)",
                             obs_addr[i], exp_addr[i], i);
                    err_count = err_count + 1;
                end
                if (obs_data[i] != exp_data[i]) begin
                    $display("[ERROR] mem_wdata = 0x%h, expected 0x%h (write %0d)",
                             obs_data[i], exp_data[i], i);
                    err_count = err_count + 1;
                end
                if (obs_cyc[i] != exp_cyc[i]) begin
                    $display("[ERROR] mem_we cycle = 0x%h, expected 0x%h (write %0d)",
                             obs_cyc[i], exp_cyc[i], i);
                    err_count = err_count + 1;
                end
            end
        end
        for (i = exp_addr.size(); i < obs_addr.size(); i++) begin
            $display("Unexpected extra write %0d: data 0x%h to address 0x%h",
                     i, obs_data[i], obs_addr[i]);
            err_count = err_count + 1;
        end
    endtask

    task automatic run_test(input int test_id, input string name);
        int errs_before;
        errs_before = err_count + mon_errs;
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        build_program(test_id);
        run_model();
        cycle_limit = cycle_limit + 3 * n_instr;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        if (mem_addr != PROG_BASE) begin
            $display("[ERROR] mem_addr = 0x%h at first fetch, expected 0x%h",
                     mem_addr, PROG_BASE);
            err_count = err_count + 1;
        end
        while (mem_addr != halt_addr) begin
            @(posedge clk);
        end
        if (cyc != halt_cyc) begin
            $display("[ERROR] halt fetch cycle = 0x%h, expected 0x%h", cyc, halt_cyc);
            err_count = err_count + 1;
        end
        compare_writes();
        $display("Test %0d %s: %0d instructions, %0d writes expected, %0d seen, %0d errors",
                 test_id, name, n_instr, exp_addr.size(), obs_addr.size(),
                 err_count + mon_errs - errs_before);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        rng_state   = 32'h667c_2505;
        cycle_limit = 100;
        err_count   = 0;
        fill_memory();
        run_test(0, "reset");
        run_test(1, "load_store_transfer");
        run_test(2, "alu_and_flags");
        run_test(3, "incdec_shift");
        run_test(4, "branch_jmp");
        $display("Tests run: 5, errors: %0d, cycles: %0d", err_count + mon_errs, total_cycles);
        if (err_count + mon_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_core.f ====
+incdir+.
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
cpu_alu.sv
cpu_regs.sv
cpu_address_unit.sv
cpu_sequencer.sv
cpu_core.sv
cpu_core_assertions.sv
tb_cpu_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f cpu_core.f \
    --top-module tb_cpu_core -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_cpu_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0
